// ==== flist.f ====
+incdir+sim
verilog/subBusPkg.sv
verilog/subAddrDecoder.sv
verilog/subTimingCtrl.sv
verilog/subBusCtrl.sv
sim/subBusCtrlTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the sub bus controller testbench with Verilator and runs it
# the result comes from the log, the simulator exit status only catches crashes

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=subBusCtrlTb

verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" \
	-Mdir "$BUILD_DIR" \
	-f flist.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

grep -qx "TEST RESULT: PASS" "$LOG_FILE"
status=$?
if [ $status -ne 0 ]; then
	echo "pass line not found in $LOG_FILE"
	exit 1
fi

echo "simulation passed, log in $LOG_FILE"
exit 0

// ==== sim/subBusModel.svh ====
`ifndef SUB_BUS_MODEL_SVH
`define SUB_BUS_MODEL_SVH

// model state, one update per rising clock edge
logic refMq;
logic refMe;
// previous nVBlank and the start seen one edge ago
logic refVbPrev;
logic refStartPend;
logic refNIrq;
logic [wdWidth-1:0] refWdCount;

// memory map as address ranges, all bounds inclusive
function automatic chipSelT decodeAddress(input logic [15:0] a);
	chipSelT s;
	s.scr0 = (a <= 16'h1FFF);
	s.scr1 = (a >= 16'h2000) && (a <= 16'h3FFF);
	s.obj = (a >= 16'h4000) && (a <= 16'h5FFF);
	s.spgm = (a >= 16'h6000) && (a <= 16'h7FFF);
	s.mpgm = (a >= 16'h8000);
	// sound chip sits in the first 1 KB of sprite ram
	s.snd = (a >= 16'h4000) && (a <= 16'h43FF);
	s.lth0 = (a >= 16'h9000) && (a <= 16'h93FF);
	s.lth1 = (a >= 16'h9400) && (a <= 16'h97FF);
	s.lth2 = (a >= 16'hA000) && (a <= 16'hA3FF);
	s.bank = (a >= 16'h8C00) && (a <= 16'h8FFF);
	s.bufEn = s.scr0 | s.scr1 | s.obj | s.snd | s.lth0 | s.lth1;
	return s;
endfunction

// sub cpu phases are the inverted main pair
function automatic cpuPhaseT predictPhase();
	cpuPhaseT p;
	p.mq = refMq;
	p.me = refMe;
	p.subE = ~refMe;
	p.subQ = ~refMq;
	return p;
endfunction

// inputs are the values held across the edge
task automatic advanceModel(input logic resetIn, input logic c2h, input logic vb,
		input logic we, input logic [15:0] a);
	logic ack;
	logic kick;
	logic start;
	ack = (a >= 16'h8400) && (a <= 16'h87FF) && !we;
	kick = (a >= 16'h8000) && (a <= 16'h83FF) && !we;
	start = refVbPrev && !vb;
	// shifter clears on reset or while the bus reset is out
	if (resetIn || refWdCount[wdWidth-1]) begin
		refMe = 1'b0;
		refMq = 1'b0;
	end else begin
		refMe = refMq;
		refMq = c2h;
	end
	if (resetIn) begin
		refNIrq = 1'b1;
		refWdCount = '0;
		refVbPrev = 1'b1;
		refStartPend = 1'b0;
	end else begin
		// ack beats a pending start
		if (ack)
			refNIrq = 1'b1;
		else if (refStartPend)
			refNIrq = 1'b0;
		if (kick)
			refWdCount = '0;
		else if (start && !refWdCount[wdWidth-1])
			refWdCount = refWdCount + 1'b1;
		refStartPend = start;
		refVbPrev = vb;
	end
endtask

`endif

// ==== sim/subBusCtrlTb.sv ====
`timescale 1ns/1ps

module subBusCtrlTb;
	import subBusPkg::*;

	// cycle budget per test phase, the timeout is derived from the sum
	localparam int resetCycles = 10;
	localparam int decodeCycles = 2000;
	localparam int phaseCycles = 500;
	localparam int mixedCycles = 5000;
	localparam int directedCycles = 400;
	localparam int totalCycles = resetCycles + decodeCycles + phaseCycles + mixedCycles +
		directedCycles;

	// page and window edges of the memory map
	localparam logic [15:0] boundaryAddr [0:24] = '{
		16'h0000, 16'h1FFF, 16'h2000, 16'h3FFF, 16'h4000, 16'h43FF, 16'h4400,
		16'h5FFF, 16'h6000, 16'h7FFF, 16'h8000, 16'h83FF, 16'h8400, 16'h8BFF,
		16'h8C00, 16'h8FFF, 16'h9000, 16'h93FF, 16'h9400, 16'h97FF, 16'h9800,
		16'hA000, 16'hA3FF, 16'hA400, 16'hFFFF
	};

	logic clk6M;
	logic rst;
	logic clk2H;
	logic nVBlank;
	logic nWe;
	subAddrT addr;
	chipSelT chipSel;
	cpuPhaseT phase;
	logic nIrq;
	logic res;

	int selErrors;
	int phaseErrors;
	int bitErrors;

	`include "subBusModel.svh"

	subBusCtrl i_dut (
		.clk6M(clk6M),
		.rst(rst),
		.clk2H(clk2H),
		.nVBlank(nVBlank),
		.nWe(nWe),
		.addr(addr),
		.chipSel(chipSel),
		.phase(phase),
		.nIrq(nIrq),
		.res(res)
	);

	// 10 ns period
	always #5 clk6M = ~clk6M;

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic checkChipSel(input chipSelT got, input chipSelT exp);
		if (got !== exp) begin
			selErrors++;
			$display("Mismatch at %0t ns: chipSel got %b expected %b", $time, got, exp);
		end
	endtask

	task automatic checkPhase(input cpuPhaseT got, input cpuPhaseT exp);
		if (got !== exp) begin
			phaseErrors++;
			$display("Mismatch at %0t ns: phase got %b expected %b", $time, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			bitErrors++;
			$display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic randomBit();
		logic [31:0] r;
		r = $urandom();
		return r[0];
	endfunction

	// the edge consumes the held inputs, new ones follow 1 ns later
	// outputs are compared at the falling edge
	task automatic runCycle(input logic r, input logic c2h, input logic vb, input logic we,
			input logic [15:0] a);
		@(posedge clk6M);
		advanceModel(rst, clk2H, nVBlank, nWe, addr.raw);
		#1;
		rst = r;
		clk2H = c2h;
		nVBlank = vb;
		nWe = we;
		addr.raw = a;
		@(negedge clk6M);
		checkChipSel(chipSel, decodeAddress(addr.raw));
		checkPhase(phase, predictPhase());
		checkBit("nIrq", nIrq, refNIrq);
		checkBit("res", res, refWdCount[wdWidth-1]);
	endtask

	// write cycle, then an idle cycle whose edge takes the write
	task automatic writeAt(input logic [15:0] a);
		runCycle(1'b0, randomBit(), 1'b1, 1'b0, a);
		runCycle(1'b0, randomBit(), 1'b1, 1'b1, 16'h0000);
	endtask

	// one vertical blank start, optionally kicked after it
	task automatic vblankPulse(input logic kick);
		runCycle(1'b0, randomBit(), 1'b0, 1'b1, 16'h0000);
		runCycle(1'b0, randomBit(), 1'b0, 1'b1, 16'h0000);
		runCycle(1'b0, randomBit(), 1'b1, !kick, kick ? 16'h8000 : 16'h0000);
		runCycle(1'b0, randomBit(), 1'b1, 1'b1, 16'h0000);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		logic [15:0] a;
		int vbLowLeft;
		cpuPhaseT cleared;
		clk6M = 1'b0;
		rst = 1'b1;
		clk2H = 1'b0;
		nVBlank = 1'b1;
		nWe = 1'b1;
		addr.raw = 16'h0000;
		selErrors = 0;
		phaseErrors = 0;
		bitErrors = 0;
		vbLowLeft = 0;
		// mq and me low, so subE and subQ high
		cleared = 4'b0011;
		void'($urandom(32'hd0c0_92da));

		// rst is high for the first 10 edges
		for (int i = 0; i < resetCycles - 1; i++)
			runCycle(1'b1, 1'b0, 1'b1, 1'b1, 16'h0000);
		runCycle(1'b0, 1'b0, 1'b1, 1'b1, 16'h0000);
		checkBit("nIrq", nIrq, 1'b1);
		checkBit("res", res, 1'b0);
		checkBit("mq", phase.mq, 1'b0);
		checkBit("me", phase.me, 1'b0);

		// decoding, reads only
		for (int i = 0; i < 25; i++)
			runCycle(1'b0, randomBit(), 1'b1, 1'b1, boundaryAddr[i]);
		for (int i = 0; i < decodeCycles; i++) begin
			r = $urandom();
			runCycle(1'b0, r[16], 1'b1, 1'b1, r[15:0]);
		end

		// phases under a random 2H
		for (int i = 0; i < phaseCycles; i++) begin
			r = $urandom();
			runCycle(1'b0, r[16], 1'b1, 1'b1, r[15:0]);
		end

		// interrupt, start seen one edge after the fall, nIrq low the edge after
		runCycle(1'b0, randomBit(), 1'b0, 1'b1, 16'h0000);
		runCycle(1'b0, randomBit(), 1'b0, 1'b1, 16'h0000);
		checkBit("nIrq", nIrq, 1'b1);
		runCycle(1'b0, randomBit(), 1'b1, 1'b1, 16'h0000);
		checkBit("nIrq", nIrq, 1'b0);
		// read of the ack page and a latch write leave it low
		runCycle(1'b0, randomBit(), 1'b1, 1'b1, 16'h8400);
		runCycle(1'b0, randomBit(), 1'b1, 1'b0, 16'h9000);
		runCycle(1'b0, randomBit(), 1'b1, 1'b1, 16'h8400);
		runCycle(1'b0, randomBit(), 1'b1, 1'b1, 16'h0000);
		checkBit("nIrq", nIrq, 1'b0);
		writeAt(16'h8400);
		checkBit("nIrq", nIrq, 1'b1);

		// watchdog, 8 unkicked starts raise res and clear the phases
		writeAt(16'h8000);
		for (int i = 0; i < 8; i++)
			vblankPulse(1'b0);
		checkBit("res", res, 1'b1);
		checkPhase(phase, cleared);
		writeAt(16'h8000);
		checkBit("res", res, 1'b0);
		// count restarted, 7 more starts stay below the limit
		for (int i = 0; i < 7; i++)
			vblankPulse(1'b0);
		checkBit("res", res, 1'b0);
		writeAt(16'h8000);
		// kick after every third start
		for (int i = 0; i < 24; i++) begin
			vblankPulse(i % 3 == 2);
			checkBit("res", res, 1'b0);
		end

		// mixed run, some accesses steered onto the kick and ack pages
		for (int i = 0; i < mixedCycles; i++) begin
			r = $urandom();
			a = r[15:0];
			if (r[20:17] == 4'd0)
				a = {6'h20, r[9:0]};
			else if (r[20:17] == 4'd1)
				a = {6'h21, r[9:0]};
			// short low pulses on nVBlank
			if (vbLowLeft > 0)
				vbLowLeft--;
			else if (r[26:24] == 3'd0)
				vbLowLeft = 3;
			runCycle(1'b0, r[21], vbLowLeft == 0, r[23:22] != 2'b00, a);
		end

		$display("error counts: chipSel %0d, phase %0d, nIrq and res %0d",
			selErrors, phaseErrors, bitErrors);
		if (selErrors + phaseErrors + bitErrors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// ends a run that overruns the cycle budget
	initial begin
		#((totalCycles + 100) * 10);
		$display("timeout: run did not finish within %0d cycles", totalCycles + 100);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== verilog/subAddrDecoder.sv ====
`timescale 1ns/1ps

module subAddrDecoder (
	input subBusPkg::subAddrT addr,
	input logic nWe,
	output subBusPkg::chipSelT chipSel,
	output subBusPkg::busStrobeT strobe
);
	import subBusPkg::*;

	// 8 KB window number
	logic [2:0] region;
	// 1 KB page number
	logic [5:0] page;
	// scr0, scr1, obj, spgm in bit order 0..3
	logic [3:0] regionSel;
	// active high copy of the cpu write strobe
	logic writeEn;
	logic sndSel;
	logic lth0Sel;
	logic lth1Sel;
	logic lth2Sel;
	logic bankSel;
	logic ackPage;
	logic kickPage;

	////////////////////////////////////////////////////////////////////////////
	// address views
	////////////////////////////////////////////////////////////////////////////

	// same word, read through the two union views
	assign region = addr.regionView.region;
	assign page = addr.pageView.page;

	// nWe is low during a cpu write cycle
	assign writeEn = ~nWe;

	////////////////////////////////////////////////////////////////////////////
	// 8 KB windows
	////////////////////////////////////////////////////////////////////////////

	// 0000h to 1FFFh, video ram plane 0
	assign regionSel[0] = (region == regionScr0);
	// 2000h to 3FFFh, video ram plane 1
	assign regionSel[1] = (region == regionScr1);
	// 4000h to 5FFFh, sprite ram
	assign regionSel[2] = (region == regionObj);
	// 6000h to 7FFFh, sub program rom
	assign regionSel[3] = (region == regionSpgm);

	////////////////////////////////////////////////////////////////////////////
	// 1 KB pages
	////////////////////////////////////////////////////////////////////////////

	// sound chip overlaps the bottom of sprite ram
	assign sndSel = (page == pageSnd);

	// scroll and priority latch banks
	assign lth0Sel = (page == pageLth0);
	assign lth1Sel = (page == pageLth1);
	assign lth2Sel = (page == pageLth2);

	// tile bank latch
	assign bankSel = (page == pageBank);

	// control pages, only meaningful on a write
	assign ackPage = (page == pageIrqAck);
	assign kickPage = (page == pageWdKick);

	////////////////////////////////////////////////////////////////////////////
	// outputs
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		chipSel.scr0 = regionSel[0];
		chipSel.scr1 = regionSel[1];
		chipSel.obj = regionSel[2];
		chipSel.spgm = regionSel[3];
		// main program rom fills the top half
		chipSel.mpgm = addr.raw[15];
		chipSel.snd = sndSel;
		chipSel.lth0 = lth0Sel;
		chipSel.lth1 = lth1Sel;
		chipSel.lth2 = lth2Sel;
		chipSel.bank = bankSel;
		// data buffer opens for video ram, sprites, sound and the two scroll latches
		// lth2 sits behind its own buffer on the board
		chipSel.bufEn = regionSel[0] | regionSel[1] | regionSel[2] | sndSel |
			lth0Sel | lth1Sel;
	end

	always_comb begin
		// reads of these pages do nothing
		strobe.irqAck = ackPage & writeEn;
		strobe.wdKick = kickPage & writeEn;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// region codes must stay distinct in the package
	// so at most one 8 KB window is ever selected
	asRegionOneHot: assert property (@(addr.raw) $onehot0(regionSel))
		else $error("subAddrDecoder: overlapping region selects %b", regionSel);

endmodule

// ==== verilog/subBusCtrl.sv ====
`timescale 1ns/1ps

module subBusCtrl (
	// 6 MHz master clock
	input logic clk6M,
	input logic rst,
	// 2H video clock, source of the cpu phases
	input logic clk2H,
	// active low vertical blank from the video timing
	input logic nVBlank,
	// active low cpu write
	input logic nWe,
	// sub cpu address
	input subBusPkg::subAddrT addr,
	output subBusPkg::chipSelT chipSel,
	output subBusPkg::cpuPhaseT phase,
	// vblank interrupt to the cpu, active low
	output logic nIrq,
	// watchdog bus reset, active high
	output logic res
);
	import subBusPkg::*;

	// ack and kick writes from the decoder
	busStrobeT strobe;

	////////////////////////////////////////////////////////////////////////////
	// memory map
	////////////////////////////////////////////////////////////////////////////

	// purely combinational, selects follow the address in the same cycle
	subAddrDecoder i_decoder (
		.addr(addr),
		.nWe(nWe),
		.chipSel(chipSel),
		.strobe(strobe)
	);

	////////////////////////////////////////////////////////////////////////////
	// clocks, interrupt and watchdog
	////////////////////////////////////////////////////////////////////////////

	// strobes act on the same edge they are decoded
	// res also holds the phase shifter clear
	subTimingCtrl i_timing (
		.clk6M(clk6M),
		.rst(rst),
		.clk2H(clk2H),
		.nVBlank(nVBlank),
		.strobe(strobe),
		.phase(phase),
		.nIrq(nIrq),
		.res(res)
	);

endmodule

// ==== verilog/subBusPkg.sv ====
package subBusPkg;

	////////////////////////////////////////////////////////////////////////////
	// board constants
	////////////////////////////////////////////////////////////////////////////

	// watchdog counter width, top bit drives the bus reset
	// 4 bits gives a timeout of 8 unkicked vertical blanks
	localparam int wdWidth = 4;

	// 8 KB region codes, address bits 15..13
	localparam logic [2:0] regionScr0 = 3'd0;
	localparam logic [2:0] regionScr1 = 3'd1;
	localparam logic [2:0] regionObj = 3'd2;
	localparam logic [2:0] regionSpgm = 3'd3;

	// 1 KB page codes, address bits 15..10
	// sound chip shared ram at 4000h
	localparam logic [5:0] pageSnd = 6'h10;
	// watchdog kick at 8000h
	localparam logic [5:0] pageWdKick = 6'h20;
	// vblank interrupt acknowledge at 8400h
	localparam logic [5:0] pageIrqAck = 6'h21;
	// tile bank select, 8C00h to 8FFFh
	localparam logic [5:0] pageBank = 6'h23;
	// scroll and priority latches, first plane pair
	localparam logic [5:0] pageLth0 = 6'h24;
	// scroll and priority latches, second plane pair
	localparam logic [5:0] pageLth1 = 6'h25;
	// background colour latch at A000h
	localparam logic [5:0] pageLth2 = 6'h28;

	////////////////////////////////////////////////////////////////////////////
	// address views
	////////////////////////////////////////////////////////////////////////////

	// 1 KB page split
	typedef struct packed {
		logic [5:0] page;
		logic [9:0] offset;
	} subPageViewT;

	// 8 KB region split
	typedef struct packed {
		logic [2:0] region;
		logic [12:0] offset;
	} subRegionViewT;

	// one cpu address word, decoded both ways
	typedef union packed {
		logic [15:0] raw;
		subPageViewT pageView;
		subRegionViewT regionView;
	} subAddrT;

	////////////////////////////////////////////////////////////////////////////
	// control bundles
	////////////////////////////////////////////////////////////////////////////

	// chip selects, all active high
	typedef struct packed {
		logic scr0;
		logic scr1;
		logic obj;
		logic snd;
		logic spgm;
		logic mpgm;
		logic lth0;
		logic lth1;
		logic lth2;
		logic bank;
		logic bufEn;
	} chipSelT;

	// write strobes into the timing block
	typedef struct packed {
		logic irqAck;
		logic wdKick;
	} busStrobeT;

	// main cpu e/q and sub cpu e/q
	typedef struct packed {
		logic mq;
		logic me;
		logic subE;
		logic subQ;
	} cpuPhaseT;

endpackage

// ==== verilog/subTimingCtrl.sv ====
`timescale 1ns/1ps

module subTimingCtrl (
	input logic clk6M,
	input logic rst,
	input logic clk2H,
	input logic nVBlank,
	input subBusPkg::busStrobeT strobe,
	output subBusPkg::cpuPhaseT phase,
	output logic nIrq,
	output logic res
);
	import subBusPkg::*;

	// two stage shift of the 2H clock
	logic mq;
	logic me;
	// shifter is held clear by board reset or the watchdog
	logic phaseClr;

	// previous nVBlank sample
	logic vblkPrev;
	// falling edge of nVBlank seen this cycle
	logic vblkStart;
	// start seen last cycle, sets the interrupt
	logic startPend;

	// counts unkicked vertical blanks
	logic [wdWidth-1:0] wdCount;

	////////////////////////////////////////////////////////////////////////////
	// e/q phase generator
	////////////////////////////////////////////////////////////////////////////

	assign phaseClr = rst | res;

	// mq follows 2H by one 6M cycle, me follows mq by one more
	always_ff @(posedge clk6M) begin
		if (phaseClr) begin
			mq <= 1'b0;
			me <= 1'b0;
		end else begin
			mq <= clk2H;
			me <= mq;
		end
	end

	// sub cpu runs on the inverted pair
	always_comb begin
		phase.mq = mq;
		phase.me = me;
		phase.subE = ~me;
		phase.subQ = ~mq;
	end

	////////////////////////////////////////////////////////////////////////////
	// vertical blank detect and interrupt latch
	////////////////////////////////////////////////////////////////////////////

	// start is a high to low step of nVBlank
	assign vblkStart = vblkPrev & ~nVBlank;

	always_ff @(posedge clk6M) begin
		if (rst) begin
			// idle level of nVBlank, so no start right after reset
			vblkPrev <= 1'b1;
			startPend <= 1'b0;
		end else begin
			vblkPrev <= nVBlank;
			startPend <= vblkStart;
		end
	end

	// nIrq is active low and held until the cpu acknowledges
	always_ff @(posedge clk6M) begin
		if (rst) begin
			nIrq <= 1'b1;
		end else if (strobe.irqAck) begin
			// ack has priority over a new start on the same edge
			nIrq <= 1'b1;
		end else if (startPend) begin
			nIrq <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// watchdog
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk6M) begin
		if (rst) begin
			wdCount <= '0;
		end else if (strobe.wdKick) begin
			wdCount <= '0;
		end else if (vblkStart && !wdCount[wdWidth-1]) begin
			// saturates once the top bit is set
			wdCount <= wdCount + 1'b1;
		end
	end

	// bus reset out, stays high until software kicks again
	assign res = wdCount[wdWidth-1];

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// me is mq delayed by one cycle whenever the shifter was running
	asPhaseLag: assert property (
		@(posedge clk6M) disable iff (rst)
		!$past(phaseClr) |-> (me == $past(mq))
	) else $error("subTimingCtrl: me does not follow mq");

	// the interrupt only asserts two edges after nVBlank falls
	asIrqAfterStart: assert property (
		@(posedge clk6M) disable iff (rst)
		$fell(nIrq) |-> $past(vblkStart, 2)
	) else $error("subTimingCtrl: nIrq fell without a vblank start");

	// once raised, res and the counter top bit hold until a kick
	asResHold: assert property (
		@(posedge clk6M) disable iff (rst)
		(res && !strobe.wdKick) |=> (res && wdCount[wdWidth-1])
	) else $error("subTimingCtrl: res dropped without a kick");

endmodule
